//--- logic/perf_config.svh
// ----------------------------------------
// MMU perf event block sizing
// Thread count, event lanes and APB widths
// ----------------------------------------
`ifndef PERF_CONFIG_SVH
`define PERF_CONFIG_SVH

// Hardware threads served by the block
`define PERF_THREADS 2

// Event bus lanes per thread and the width of one lane select
`define PERF_LANES 4
`define PERF_SEL_W 5

`define PERF_APB_AW 4
`define PERF_APB_DW 32

`endif

//--- logic/perf_reg_pkg.sv
// ----------------------------------------
// MMU perf register map
// APB offsets and control register layout
// ----------------------------------------
`include "perf_config.svh"

package perf_reg_pkg;

   localparam logic [`PERF_APB_AW-1:0] PERF_CTRL_ADDR = 'h0;
   localparam logic [`PERF_APB_AW-1:0] PERF_MUX_T0_ADDR = 'h4;
   localparam logic [`PERF_APB_AW-1:0] PERF_MUX_T1_ADDR = 'h8;

   // Privilege states in which events are counted
   typedef struct packed {
      logic hyp;
      logic guest;
      logic user;
   } perf_count_mode_t;

   // CTRL register bit 0 is the bus enable, bits 1 to 3 the count mode
   typedef struct packed {
      perf_count_mode_t count_mode;
      logic             bus_enable;
   } perf_ctrl_t;

   // One select per lane, lane k in bits 5k to 5k+4 of a MUX register
   typedef logic [`PERF_LANES-1:0][`PERF_SEL_W-1:0] perf_lane_sel_t;

endpackage

//--- logic/perf_event_pkg.sv
// ----------------------------------------
// MMU perf event types
// Input bundles, event vectors, mux view
// ----------------------------------------
`include "perf_config.svh"

package perf_event_pkg;

   typedef struct packed {
      logic                     valid;
      logic                     nonspec;
      logic [`PERF_THREADS-1:0] thdid;
   } perf_erat_req_t;

   // TLB compare results that are counted at core level, miss_direct in bit 0
   typedef struct packed {
      logic pt_fault;
      logic lrat_miss;
      logic lrat_request;
      logic ptereload;
      logic hit_first_page;
      logic hit_indirect;
      logic hit_direct;
      logic miss_direct;
   } perf_tlb_ev_t;

   // State: bit 0 set is problem, 2 is guest supervisor, 0 is hypervisor
   typedef struct packed {
      logic [1:0]   state;
      logic         tag4_nonspec;
      perf_tlb_ev_t ev;
   } perf_tlb_core_t;

   typedef struct packed {
      logic tlb_flush;
      logic tlbivax_snoop;
      logic tlbivax;
      logic tlbilx;
   } perf_inval_t;

   typedef logic [9:0] perf_cmp_vec_t;

   typedef struct packed {
      logic          cmp0_nonspec;
      logic          derat_req_nonspec;
      logic          ierat_req_nonspec;
      logic          derat_req;
      logic          ierat_req;
      perf_cmp_vec_t cmp;
   } perf_thread_ev_t;

   typedef struct packed {
      logic         miss_direct_nonspec;
      logic         erat_taken_nonspec;
      logic         derat_taken;
      logic         ierat_taken;
      perf_inval_t  inval;
      perf_tlb_ev_t tlb;
   } perf_core_ev_t;

   typedef struct packed {
      perf_core_ev_t   core_ev;
      perf_thread_ev_t thread_ev;
      logic            rsvd;
   } perf_unit_fields_t;

   // Flat view is indexed directly by the lane select number
   typedef union packed {
      logic [31:0]       flat;
      perf_unit_fields_t fields;
   } perf_unit_events_u;

   typedef logic [`PERF_LANES-1:0] perf_bus_t;

endpackage

//--- logic/perf_ctrl_regs.sv
// ----------------------------------------
// Perf control register block
// APB slave for CTRL and lane select regs
// ----------------------------------------
`timescale 1ns/1ns
`include "perf_config.svh"

module perf_ctrl_regs (
   input  logic                                          nclk,
   input  logic                                          rst_n,
   input  logic [`PERF_APB_AW-1:0]                       paddr,
   input  logic                                          psel,
   input  logic                                          penable,
   input  logic                                          pwrite,
   input  logic [`PERF_APB_DW-1:0]                       pwdata,
   output logic [`PERF_APB_DW-1:0]                       prdata,
   output logic                                          pready,
   output logic                                          pslverr,
   output perf_reg_pkg::perf_ctrl_t                      ctrl,
   output perf_reg_pkg::perf_lane_sel_t [`PERF_THREADS-1:0] lane_sel
);
   import perf_reg_pkg::*;

   logic                    addr_hit;
   logic                    setup_phase;
   logic                    wr_en;
   logic [`PERF_APB_DW-1:0] rdata;

   assign pready = 1'b1;

   assign addr_hit = (paddr == PERF_CTRL_ADDR) || (paddr == PERF_MUX_T0_ADDR) ||
                     (paddr == PERF_MUX_T1_ADDR);
   assign setup_phase = psel & ~penable;
   assign wr_en = psel & penable & pwrite & addr_hit;

   always_comb begin
      rdata = '0;
      case (paddr)
         PERF_CTRL_ADDR: rdata[$bits(perf_ctrl_t)-1:0] = ctrl;
         PERF_MUX_T0_ADDR: rdata[$bits(perf_lane_sel_t)-1:0] = lane_sel[0];
         PERF_MUX_T1_ADDR: rdata[$bits(perf_lane_sel_t)-1:0] = lane_sel[1];
         default: rdata = '0;
      endcase
   end

   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         ctrl <= '0;
         lane_sel <= '0;
      end else if (wr_en) begin
         case (paddr)
            PERF_CTRL_ADDR: ctrl <= pwdata[$bits(perf_ctrl_t)-1:0];
            PERF_MUX_T0_ADDR: lane_sel[0] <= pwdata[$bits(perf_lane_sel_t)-1:0];
            PERF_MUX_T1_ADDR: lane_sel[1] <= pwdata[$bits(perf_lane_sel_t)-1:0];
            default: ;
         endcase
      end
   end

   // Response is prepared in the setup phase so it is valid for the
   // whole access phase with no wait states
   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         prdata <= '0;
         pslverr <= 1'b0;
      end else begin
         pslverr <= setup_phase & ~addr_hit;
         if (setup_phase && !pwrite) begin
            prdata <= rdata;
         end else begin
            prdata <= '0;
         end
      end
   end

endmodule

//--- logic/perf_event_gen.sv
// ----------------------------------------
// Perf event generation
// Count-mode gating, per-thread/core events
// ----------------------------------------
`timescale 1ns/1ns
`include "perf_config.svh"

module perf_event_gen (
   input  logic                                            nclk,
   input  logic                                            rst_n,
   input  perf_reg_pkg::perf_ctrl_t                        ctrl,
   input  logic [`PERF_THREADS-1:0]                        msr_gs,
   input  logic [`PERF_THREADS-1:0]                        msr_pr,
   input  perf_event_pkg::perf_cmp_vec_t [`PERF_THREADS-1:0] tlb_cmp,
   input  perf_event_pkg::perf_erat_req_t [1:0]            ierat_req,
   input  perf_event_pkg::perf_erat_req_t [1:0]            derat_req,
   input  perf_event_pkg::perf_tlb_core_t                  tlb_core,
   input  perf_event_pkg::perf_inval_t                     inval,
   input  logic                                            ierat_req_taken,
   input  logic                                            derat_req_taken,
   input  logic                                            tag0_nonspec,
   output perf_event_pkg::perf_unit_events_u [`PERF_THREADS-1:0] unit_events
);
   import perf_reg_pkg::*;
   import perf_event_pkg::*;

   logic [`PERF_THREADS-1:0]             msr_gs_q;
   logic [`PERF_THREADS-1:0]             msr_pr_q;
   logic [`PERF_THREADS-1:0]             thread_en;
   logic                                 core_en;
   perf_thread_ev_t [`PERF_THREADS-1:0]  thread_ev_d;
   perf_thread_ev_t [`PERF_THREADS-1:0]  thread_ev_q;
   perf_core_ev_t                        core_ev_d;
   perf_core_ev_t                        core_ev_q;

   // Problem state wins over guest, hypervisor is neither
   function automatic logic mode_match(input logic pr, input logic gs,
                                       input perf_count_mode_t mode);
      return (pr & mode.user) | (~pr & gs & mode.guest) | (~pr & ~gs & mode.hyp);
   endfunction

   always_comb begin
      for (int t = 0; t < `PERF_THREADS; t++) begin
         thread_en[t] = mode_match(msr_pr_q[t], msr_gs_q[t], ctrl.count_mode);
      end
   end

   // TLB state maps onto the same rule with bit 0 as pr and bit 1 as gs
   assign core_en = mode_match(tlb_core.state[0], tlb_core.state[1], ctrl.count_mode);

   always_comb begin
      thread_ev_d = '0;
      for (int t = 0; t < `PERF_THREADS; t++) begin
         thread_ev_d[t].cmp = tlb_cmp[t] & {$bits(perf_cmp_vec_t){thread_en[t]}};
         thread_ev_d[t].cmp0_nonspec = tlb_cmp[t][0] & thread_en[t] & tlb_core.tag4_nonspec;
         for (int p = 0; p < 2; p++) begin
            thread_ev_d[t].ierat_req |= ierat_req[p].valid & ierat_req[p].thdid[t];
            thread_ev_d[t].derat_req |= derat_req[p].valid & derat_req[p].thdid[t];
            thread_ev_d[t].ierat_req_nonspec |=
               ierat_req[p].valid & ierat_req[p].nonspec & ierat_req[p].thdid[t];
            thread_ev_d[t].derat_req_nonspec |=
               derat_req[p].valid & derat_req[p].nonspec & derat_req[p].thdid[t];
         end
      end
   end

   always_comb begin
      core_ev_d.tlb = tlb_core.ev & {$bits(perf_tlb_ev_t){core_en}};
      core_ev_d.inval = inval;
      core_ev_d.ierat_taken = ierat_req_taken;
      core_ev_d.derat_taken = derat_req_taken;
      core_ev_d.erat_taken_nonspec = (ierat_req_taken | derat_req_taken) & tag0_nonspec;
      core_ev_d.miss_direct_nonspec = tlb_core.ev.miss_direct & core_en &
                                      tlb_core.tag4_nonspec;
   end

   // All event stage state freezes while the bus is disabled
   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         msr_gs_q <= '0;
         msr_pr_q <= '0;
         thread_ev_q <= '0;
         core_ev_q <= '0;
      end else if (ctrl.bus_enable) begin
         msr_gs_q <= msr_gs;
         msr_pr_q <= msr_pr;
         thread_ev_q <= thread_ev_d;
         core_ev_q <= core_ev_d;
      end
   end

   always_comb begin
      for (int t = 0; t < `PERF_THREADS; t++) begin
         unit_events[t].fields.rsvd = 1'b0;
         unit_events[t].fields.thread_ev = thread_ev_q[t];
         unit_events[t].fields.core_ev = core_ev_q;
      end
   end

endmodule

//--- logic/perf_event_mux.sv
// ----------------------------------------
// Perf event bus multiplexer
// Per-thread lane select, registered out
// ----------------------------------------
`timescale 1ns/1ns
`include "perf_config.svh"

module perf_event_mux (
   input  logic                                               nclk,
   input  logic                                               rst_n,
   input  logic                                               bus_enable,
   input  perf_reg_pkg::perf_lane_sel_t [`PERF_THREADS-1:0]    lane_sel,
   input  perf_event_pkg::perf_unit_events_u [`PERF_THREADS-1:0] unit_events,
   input  perf_event_pkg::perf_bus_t [`PERF_THREADS-1:0]       mm_event_bus_in,
   output perf_event_pkg::perf_bus_t [`PERF_THREADS-1:0]       mm_event_bus_out
);
   import perf_event_pkg::*;

   perf_bus_t [`PERF_THREADS-1:0] bus_d;

   // Select 0 chains the upstream lane through, any other value picks
   // that bit of the unit event word
   always_comb begin
      for (int t = 0; t < `PERF_THREADS; t++) begin
         for (int l = 0; l < `PERF_LANES; l++) begin
            if (lane_sel[t][l] == '0) begin
               bus_d[t][l] = mm_event_bus_in[t][l];
            end else begin
               bus_d[t][l] = unit_events[t].flat[lane_sel[t][l]];
            end
         end
      end
   end

   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         mm_event_bus_out <= '0;
      end else if (bus_enable) begin
         mm_event_bus_out <= bus_d;
      end
   end

endmodule

//--- logic/mmu_perf_top.sv
// ----------------------------------------
// MMU perf event block top level
// Registers, event stage and bus mux
// ----------------------------------------
`timescale 1ns/1ns
`include "perf_config.svh"

module mmu_perf_top (
   input  logic                                              nclk,
   input  logic                                              rst_n,
   input  logic [`PERF_APB_AW-1:0]                           paddr,
   input  logic                                              psel,
   input  logic                                              penable,
   input  logic                                              pwrite,
   input  logic [`PERF_APB_DW-1:0]                           pwdata,
   output logic [`PERF_APB_DW-1:0]                           prdata,
   output logic                                              pready,
   output logic                                              pslverr,
   input  logic [`PERF_THREADS-1:0]                          msr_gs,
   input  logic [`PERF_THREADS-1:0]                          msr_pr,
   input  perf_event_pkg::perf_cmp_vec_t [`PERF_THREADS-1:0] tlb_cmp,
   input  perf_event_pkg::perf_erat_req_t [1:0]              ierat_req,
   input  perf_event_pkg::perf_erat_req_t [1:0]              derat_req,
   input  perf_event_pkg::perf_tlb_core_t                    tlb_core,
   input  perf_event_pkg::perf_inval_t                       inval,
   input  logic                                              ierat_req_taken,
   input  logic                                              derat_req_taken,
   input  logic                                              tag0_nonspec,
   input  perf_event_pkg::perf_bus_t [`PERF_THREADS-1:0]     mm_event_bus_in,
   output perf_event_pkg::perf_bus_t [`PERF_THREADS-1:0]     mm_event_bus_out
);
   import perf_reg_pkg::*;
   import perf_event_pkg::*;

   perf_ctrl_t                              ctrl;
   perf_lane_sel_t [`PERF_THREADS-1:0]      lane_sel;
   perf_unit_events_u [`PERF_THREADS-1:0]   unit_events;

   perf_ctrl_regs regs_i (
      .nclk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
      .prdata, .pready, .pslverr, .ctrl, .lane_sel
   );

   perf_event_gen gen_i (
      .nclk, .rst_n, .ctrl, .msr_gs, .msr_pr, .tlb_cmp, .ierat_req, .derat_req,
      .tlb_core, .inval, .ierat_req_taken, .derat_req_taken, .tag0_nonspec,
      .unit_events
   );

   perf_event_mux mux_i (
      .nclk, .rst_n, .bus_enable(ctrl.bus_enable), .lane_sel, .unit_events,
      .mm_event_bus_in, .mm_event_bus_out
   );

endmodule

//--- dv/mmu_perf_sva.sv
// ----------------------------------------
// MMU perf assertions
// APB response rules and event bus freeze
// ----------------------------------------
`timescale 1ns/1ns
`include "perf_config.svh"

module mmu_perf_sva (
   input logic                                           nclk,
   input logic                                           rst_n,
   input logic                                           psel,
   input logic                                           penable,
   input logic                                           pready,
   input logic                                           pslverr,
   input logic                                           bus_enable,
   input perf_event_pkg::perf_bus_t [`PERF_THREADS-1:0]  bus_out
);

   // An error response only ever shows in the access phase
   assert property (@(posedge nclk) disable iff (!rst_n) pslverr |-> (psel && penable))
      else $error("pslverr outside an APB access phase");

   assert property (@(posedge nclk) disable iff (!rst_n) pready)
      else $error("pready dropped");

   // Output lanes hold for as long as the bus is disabled
   assert property (@(posedge nclk) disable iff (!rst_n) !bus_enable |=> $stable(bus_out))
      else $error("event bus changed while disabled");

endmodule

bind perf_ctrl_regs mmu_perf_sva apb_sva_i (
   .nclk, .rst_n, .psel, .penable, .pready, .pslverr, .bus_enable(1'b1), .bus_out('0)
);

bind perf_event_mux mmu_perf_sva bus_sva_i (
   .nclk, .rst_n, .psel(1'b0), .penable(1'b0), .pready(1'b1), .pslverr(1'b0),
   .bus_enable, .bus_out(mm_event_bus_out)
);

//--- dv/mmu_perf_tb.sv
// ----------------------------------------
// MMU perf event block testbench
// Table of pulses and expected bus lanes
// ----------------------------------------
`timescale 1ns/1ns
`include "perf_config.svh"

module mmu_perf_tb;
   import perf_reg_pkg::*;
   import perf_event_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int NUM_TESTS = 9;

   typedef perf_bus_t [`PERF_THREADS-1:0] bus_pair_t;
   typedef perf_lane_sel_t [`PERF_THREADS-1:0] sel_pair_t;

   // All event inputs of the DUT, applied together for one cycle
   typedef struct packed {
      perf_cmp_vec_t [`PERF_THREADS-1:0] cmp;
      perf_erat_req_t [1:0]              ireq;
      perf_erat_req_t [1:0]              dreq;
      perf_tlb_core_t                    core;
      perf_inval_t                       inval;
      logic                              itaken;
      logic                              dtaken;
      logic                              tag0;
   } pulse_t;

   logic                     nclk = 1'b0;
   logic                     rst_n;
   logic [`PERF_APB_AW-1:0]  paddr;
   logic                     psel;
   logic                     penable;
   logic                     pwrite;
   logic [`PERF_APB_DW-1:0]  pwdata;
   logic [`PERF_APB_DW-1:0]  prdata;
   logic                     pready;
   logic                     pslverr;
   logic [`PERF_THREADS-1:0] msr_gs;
   logic [`PERF_THREADS-1:0] msr_pr;
   pulse_t                   pulse;
   bus_pair_t                bus_in;
   bus_pair_t                bus_out;

   string                    t_name[NUM_TESTS];
   logic [3:0]               t_ctrl[NUM_TESTS];
   sel_pair_t                t_sel[NUM_TESTS];
   logic [`PERF_THREADS-1:0] t_pr[NUM_TESTS];
   logic [`PERF_THREADS-1:0] t_gs[NUM_TESTS];
   pulse_t                   t_pulse[NUM_TESTS];
   bus_pair_t                t_in[NUM_TESTS];
   bus_pair_t                t_exp[NUM_TESTS];
   int                       n_tests = 0;
   int                       n_checks = 0;
   int                       n_errors = 0;
   integer                   seed = 74466;
   logic [`PERF_APB_DW-1:0]  rd;
   logic                     err;

   mmu_perf_top dut_i (
      .nclk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
      .msr_gs, .msr_pr, .tlb_cmp(pulse.cmp), .ierat_req(pulse.ireq), .derat_req(pulse.dreq),
      .tlb_core(pulse.core), .inval(pulse.inval), .ierat_req_taken(pulse.itaken),
      .derat_req_taken(pulse.dtaken), .tag0_nonspec(pulse.tag0),
      .mm_event_bus_in(bus_in), .mm_event_bus_out(bus_out)
   );

   always #(CLK_PERIOD / 2) nclk = ~nclk;

   initial begin
      #((NUM_TESTS * 10 + 100) * CLK_PERIOD);
      $display("ERROR: watchdog expired before all tests completed");
      $display("Done: errors found");
      $finish;
   end

   task automatic write_reg(input logic [`PERF_APB_AW-1:0] addr, input logic [31:0] data);
      @(posedge nclk);
      psel <= 1'b1;
      penable <= 1'b0;
      pwrite <= 1'b1;
      paddr <= addr;
      pwdata <= data;
      @(posedge nclk);
      penable <= 1'b1;
      @(posedge nclk);
      psel <= 1'b0;
      penable <= 1'b0;
   endtask

   // Response is sampled in the middle of the access phase
   task automatic read_reg(input logic [`PERF_APB_AW-1:0] addr, output logic [31:0] data,
                           output logic slv_err);
      @(posedge nclk);
      psel <= 1'b1;
      penable <= 1'b0;
      pwrite <= 1'b0;
      paddr <= addr;
      @(posedge nclk);
      penable <= 1'b1;
      @(negedge nclk);
      data = prdata;
      slv_err = pslverr;
      check_value("pready in access phase", 32'(pready), 32'h1);
      @(posedge nclk);
      psel <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   function automatic perf_lane_sel_t lanes(input int l0, input int l1, input int l2,
                                            input int l3);
      perf_lane_sel_t s;
      s[0] = 5'(l0);
      s[1] = 5'(l1);
      s[2] = 5'(l2);
      s[3] = 5'(l3);
      return s;
   endfunction

   // Lanes with select 0 carry the incoming bus instead of an event
   function automatic bus_pair_t pass_lanes(input sel_pair_t sel);
      bus_pair_t m;
      for (int t = 0; t < `PERF_THREADS; t++) begin
         for (int l = 0; l < `PERF_LANES; l++) begin
            m[t][l] = (sel[t][l] == '0);
         end
      end
      return m;
   endfunction

   task automatic add_test(input string name, input logic [3:0] ctrl, input perf_lane_sel_t s0,
                           input perf_lane_sel_t s1, input logic [1:0] pr, input logic [1:0] gs,
                           input pulse_t p, input perf_bus_t in0, input perf_bus_t in1,
                           input perf_bus_t exp0, input perf_bus_t exp1);
      t_name[n_tests] = name;
      t_ctrl[n_tests] = ctrl;
      t_sel[n_tests] = {s1, s0};
      t_pr[n_tests] = pr;
      t_gs[n_tests] = gs;
      t_pulse[n_tests] = p;
      t_in[n_tests] = {in1, in0};
      t_exp[n_tests] = {exp1, exp0};
      n_tests++;
   endtask

   // CTRL is {hyp, guest, user, bus_enable}, expected values cover event lanes only
   task automatic build_table();
      pulse_t p;
      p = '0;
      p.cmp[0] = 10'h005;
      p.core.tag4_nonspec = 1'b1;
      add_test("compare t0 in user mode", 4'h3, lanes(1, 3, 0, 15), lanes(1, 3, 11, 0),
               2'b01, 2'b00, p, 4'hA, 4'hC, 4'hB, 4'h0);
      add_test("compare t0 with user mode off", 4'h5, lanes(1, 3, 0, 15), lanes(1, 3, 11, 0),
               2'b01, 2'b00, p, 4'h5, 4'h3, 4'h0, 4'h0);
      p.cmp[1] = 10'h005;
      add_test("compare t0 in guest mode", 4'h5, lanes(1, 3, 0, 15), lanes(1, 3, 11, 0),
               2'b00, 2'b01, p, 4'h0, 4'hF, 4'hB, 4'h0);
      p = '0;
      p.ireq[0] = 4'b1111;
      p.dreq[1] = 4'b1001;
      add_test("erat requests", 4'hF, lanes(11, 12, 13, 14), lanes(11, 12, 13, 14),
               2'b00, 2'b00, p, 4'h0, 4'h0, 4'h7, 4'h5);
      p = '0;
      p.core.state = 2'b01;
      p.core.tag4_nonspec = 1'b1;
      p.core.ev.miss_direct = 1'b1;
      p.core.ev.hit_direct = 1'b1;
      p.inval = 4'b1001;
      p.itaken = 1'b1;
      add_test("core events in problem state", 4'h3, lanes(16, 17, 31, 0), lanes(16, 24, 27, 28),
               2'b00, 2'b00, p, 4'hF, 4'h0, 4'h7, 4'hF);
      add_test("core events gated", 4'h5, lanes(16, 17, 31, 0), lanes(16, 24, 27, 28),
               2'b00, 2'b00, p, 4'h0, 4'h0, 4'h0, 4'hE);
      p = '0;
      p.cmp[0] = 10'h3FF;
      add_test("incoming lanes pass through", 4'hF, lanes(0, 0, 0, 0), lanes(0, 0, 0, 0),
               2'b00, 2'b00, p, 4'h9, 4'h6, 4'h0, 4'h0);
      p.cmp[1] = 10'h001;
      p.core.ev.miss_direct = 1'b1;
      p.inval = 4'b0001;
      add_test("bus disabled holds output", 4'hE, lanes(0, 0, 1, 1), lanes(0, 16, 0, 24),
               2'b00, 2'b00, p, 4'hF, 4'hF, 4'h0, 4'h0);
      p.cmp[0] = 10'h001;
      add_test("bus enabled again", 4'h9, lanes(1, 0, 16, 24), lanes(1, 0, 16, 24),
               2'b00, 2'b00, p, 4'h0, 4'h2, 4'hD, 4'hD);
   endtask

   task automatic apply_test(input int i);
      bus_pair_t bg;
      bus_pair_t pass;
      bus_pair_t in_val;
      int        start;
      start = n_errors;
      bg = bus_pair_t'($random(seed));
      @(posedge nclk);
      msr_pr <= t_pr[i];
      msr_gs <= t_gs[i];
      bus_in <= bg;
      write_reg(PERF_MUX_T0_ADDR, 32'(t_sel[i][0]));
      write_reg(PERF_MUX_T1_ADDR, 32'(t_sel[i][1]));
      write_reg(PERF_CTRL_ADDR, 32'(t_ctrl[i]));
      pass = pass_lanes(t_sel[i]);
      // A frozen bus keeps the background lanes loaded before the disable
      in_val = t_ctrl[i][0] ? t_in[i] : bg;
      repeat (2) @(posedge nclk);
      pulse <= t_pulse[i];
      bus_in <= t_in[i];
      @(posedge nclk);
      pulse <= '0;
      @(negedge nclk);
      check_value($sformatf("test %0d incoming lanes", i), 32'(bus_out & pass),
                  32'(in_val & pass));
      @(negedge nclk);
      check_value($sformatf("test %0d event lanes", i), 32'(bus_out),
                  32'((t_exp[i] & ~pass) | (in_val & pass)));
      $display("test %0d %s: %s", i, t_name[i], (n_errors == start) ? "ok" : "FAILED");
   endtask

   initial begin
      rst_n <= 1'b0;
      psel <= 1'b0;
      penable <= 1'b0;
      pwrite <= 1'b0;
      paddr <= '0;
      pwdata <= '0;
      msr_gs <= '0;
      msr_pr <= '0;
      pulse <= '0;
      bus_in <= '0;
      build_table();
      repeat (2) @(posedge nclk);
      rst_n <= 1'b1;
      @(negedge nclk);
      check_value("bus after reset", 32'(bus_out), 32'h0);
      check_value("prdata after reset", prdata, 32'h0);
      write_reg(PERF_CTRL_ADDR, 32'hFFFF_FFFF);
      write_reg(PERF_MUX_T0_ADDR, 32'hFFFF_FFFF);
      write_reg(PERF_MUX_T1_ADDR, 32'hA5A5_A5A5);
      write_reg(4'hC, 32'hFFFF_FFFF);
      read_reg(PERF_CTRL_ADDR, rd, err);
      check_value("CTRL read", rd, 32'h0000_000F);
      read_reg(PERF_MUX_T0_ADDR, rd, err);
      check_value("MUX0 read", rd, 32'h000F_FFFF);
      read_reg(PERF_MUX_T1_ADDR, rd, err);
      check_value("MUX1 read", rd, 32'h0005_A5A5);
      read_reg(4'hC, rd, err);
      check_value("read at 12", rd, 32'h0);
      check_value("pslverr at 12", 32'(err), 32'h1);
      $display("test reset and register access: %s", (n_errors == 0) ? "ok" : "FAILED");
      for (int i = 0; i < NUM_TESTS; i++) begin
         apply_test(i);
      end
      $display("%0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- vlog.f
+incdir+logic
logic/perf_reg_pkg.sv
logic/perf_event_pkg.sv
logic/perf_ctrl_regs.sv
logic/perf_event_gen.sv
logic/perf_event_mux.sv
logic/mmu_perf_top.sv
dv/mmu_perf_sva.sv
dv/mmu_perf_tb.sv

//--- run.sh
#!/bin/sh
# Build the MMU perf testbench with Verilator, run it and judge the log
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module mmu_perf_tb -o mmu_perf_sim \
   && ./obj_dir/mmu_perf_sim > sim.log 2>&1
cat sim.log 2>/dev/null
[ -s sim.log ] || { echo "build or run failed, no log produced"; exit 1; }
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
